/* can_rx_pkg.sv */
package can_rx_pkg;

	// ====================
	// Field lengths in bits
	// ====================

	// Base identifier
	localparam int LEN_ID_A = 11;
	// Identifier extension of extended frames
	localparam int LEN_ID_B = 18;
	localparam int LEN_DLC = 4;
	localparam int LEN_CRC = 15;
	// End of frame, also the recessive run that ends error recovery
	localparam int LEN_EOF = 7;
	// Third intermission bit may already be the next SOF
	localparam int LEN_INTERMISSION = 2;

	// Equal bits before the transmitter inserts a stuff bit
	localparam int STUFF_LIMIT = 5;
	// DLC values above eight still carry eight bytes
	localparam int MAX_DATA_BYTES = 8;

	// ====================
	// Field types
	// ====================

	typedef logic [LEN_ID_A-1:0] can_id_a_t;
	typedef logic [LEN_ID_B-1:0] can_id_b_t;
	typedef logic [LEN_DLC-1:0] can_dlc_t;
	typedef logic [8*MAX_DATA_BYTES-1:0] can_data_t;
	typedef logic [LEN_CRC-1:0] can_crc_t;
	// Bit position inside one field, up to 64 data bits
	typedef logic [6:0] bit_count_t;

	// CAN CRC-15 generator without the x^15 term
	localparam can_crc_t CRC_POLY = 15'h4599;

	// ====================
	// Enums and frame
	// ====================

	// Frame walk, one step per de-stuffed bit
	typedef enum logic [4:0] {
		ST_IDLE,
		ST_ID_A,
		ST_SRR_RTR,
		ST_IDE,
		ST_ID_B,
		ST_RTR,
		ST_RES1,
		ST_RES0,
		ST_DLC,
		ST_DATA,
		ST_CRC,
		ST_CRC_DELIM,
		ST_ACK_SLOT,
		ST_ACK_DELIM,
		ST_EOF,
		ST_INTERMISSION,
		ST_ERROR_WAIT
	} can_state_t;

	// One classified error per frame
	typedef enum logic [2:0] {
		ERR_NONE,
		ERR_STUFF,
		ERR_CRC,
		ERR_FORM,
		ERR_ACK
	} can_error_t;

	// Decoded frame, id_b zero for standard frames
	// Last received data byte ends up in data[7:0]
	typedef struct packed {
		can_id_a_t id_a;
		can_id_b_t id_b;
		logic      ide;
		logic      rtr;
		can_dlc_t  dlc;
		can_data_t data;
		can_crc_t  crc;
	} can_frame_t;

endpackage

/* can_destuffer.sv */
`timescale 1ns/10ps

module can_destuffer (
	input  logic clock,
	input  logic reset,
	input  logic rx_bit,
	input  logic sample_point,
	input  logic stuff_enable,
	output logic bit_strobe,
	output logic stuff_error
);

	// Length of the current run of equal bits
	logic [2:0] run_count;
	// Previous sampled bus level
	logic       last_bit;
	// This sample sits where a stuff bit must appear
	logic       stuff_slot;

	// ====================
	// Stuff bit decode
	// ====================

	assign stuff_slot = stuff_enable && (run_count == 3'(can_rx_pkg::STUFF_LIMIT));

	// Sixth equal bit in a row breaks the stuffing rule
	assign stuff_error = sample_point && stuff_slot && (rx_bit == last_bit);

	// Complementary bit in the stuff slot gets swallowed
	assign bit_strobe = sample_point && !(stuff_slot && (rx_bit != last_bit));

	// ====================
	// Run tracking
	// ====================

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			run_count <= 3'd1;
			last_bit  <= 1'b1;
		end
		else if (sample_point)
		begin
			last_bit <= rx_bit;
			// Outside the stuffed region each bit starts a new run
			// A removed stuff bit also opens the next run
			if (!stuff_enable || (rx_bit != last_bit))
				run_count <= 3'd1;
			else if (!stuff_slot)
				run_count <= run_count + 3'd1;
		end
	end

	// Errors only inside the region the frame FSM marks as stuffed
	a_stuff_err_in_region: assert property (@(posedge clock) disable iff (reset)
		stuff_error |-> stuff_enable);

endmodule

/* can_crc15.sv */
`timescale 1ns/10ps

module can_crc15 (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 crc_clear,
	input  logic                 crc_shift,
	input  logic                 data_bit,
	output can_rx_pkg::can_crc_t crc_value
);

	// Incoming bit against the register MSB
	logic feedback;

	assign feedback = data_bit ^ crc_value[can_rx_pkg::LEN_CRC-1];

	// ====================
	// CRC-15 register
	// ====================

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			crc_value <= '0;
		else if (crc_clear)
			crc_value <= '0;
		else if (crc_shift)
		begin
			// Shift left, fold in the polynomial on feedback
			if (feedback)
				crc_value <= {crc_value[can_rx_pkg::LEN_CRC-2:0], 1'b0} ^ can_rx_pkg::CRC_POLY;
			else
				crc_value <= {crc_value[can_rx_pkg::LEN_CRC-2:0], 1'b0};
		end
	end

	// FSM must never restart and feed the register in one cycle
	a_clear_shift_excl: assert property (@(posedge clock) disable iff (reset)
		!(crc_clear && crc_shift));

endmodule

/* can_frame_fsm.sv */
`timescale 1ns/10ps

module can_frame_fsm (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   rx_bit,
	input  logic                   bit_strobe,
	input  logic                   stuff_error,
	input  can_rx_pkg::can_crc_t   crc_value,
	output logic                   stuff_enable,
	output logic                   crc_clear,
	output logic                   crc_shift,
	output can_rx_pkg::can_frame_t frame,
	output logic                   frame_valid,
	output can_rx_pkg::can_error_t error_kind,
	output logic                   error_valid
);

	can_rx_pkg::can_state_t state;
	can_rx_pkg::can_state_t state_next;
	// Error caused by the bit on the bus right now
	can_rx_pkg::can_error_t bit_err;
	// Shared counter for all multi-bit fields
	can_rx_pkg::bit_count_t bit_cnt;
	can_rx_pkg::bit_count_t field_last;
	can_rx_pkg::bit_count_t data_len;
	can_rx_pkg::can_dlc_t   dlc_next;
	can_rx_pkg::can_dlc_t   dlc_bytes;
	// Frame under construction
	can_rx_pkg::can_frame_t cur;
	logic                   field_done;
	logic                   frame_done;

	// ====================
	// Field bookkeeping
	// ====================

	// DLC including the bit being sampled now
	assign dlc_next = can_rx_pkg::can_dlc_t'({cur.dlc, rx_bit});
	// Clamp to eight bytes, then bits
	assign dlc_bytes = (cur.dlc > can_rx_pkg::can_dlc_t'(can_rx_pkg::MAX_DATA_BYTES)) ?
		can_rx_pkg::can_dlc_t'(can_rx_pkg::MAX_DATA_BYTES) : cur.dlc;
	assign data_len = can_rx_pkg::bit_count_t'({dlc_bytes, 3'b000});

	// Index of the last bit of the current field
	always_comb
	begin
		case (state)
			can_rx_pkg::ST_ID_A:         field_last = 7'(can_rx_pkg::LEN_ID_A - 1);
			can_rx_pkg::ST_ID_B:         field_last = 7'(can_rx_pkg::LEN_ID_B - 1);
			can_rx_pkg::ST_DLC:          field_last = 7'(can_rx_pkg::LEN_DLC - 1);
			can_rx_pkg::ST_DATA:         field_last = data_len - 7'd1;
			can_rx_pkg::ST_CRC:          field_last = 7'(can_rx_pkg::LEN_CRC - 1);
			can_rx_pkg::ST_EOF:          field_last = 7'(can_rx_pkg::LEN_EOF - 1);
			can_rx_pkg::ST_ERROR_WAIT:   field_last = 7'(can_rx_pkg::LEN_EOF - 1);
			can_rx_pkg::ST_INTERMISSION: field_last = 7'(can_rx_pkg::LEN_INTERMISSION - 1);
			default:                     field_last = '0;
		endcase
	end

	assign field_done = (bit_cnt == field_last);

	// ====================
	// Bit checks
	// ====================

	always_comb
	begin
		bit_err = can_rx_pkg::ERR_NONE;
		if (stuff_error)
			bit_err = can_rx_pkg::ERR_STUFF;
		else
		begin
			case (state)
				// Recessive IDE makes the earlier bit an SRR, which must be recessive
				can_rx_pkg::ST_IDE:
					if (rx_bit && !cur.rtr)
						bit_err = can_rx_pkg::ERR_FORM;
				// Delimiter form first, then the CRC compare
				can_rx_pkg::ST_CRC_DELIM:
					if (!rx_bit)
						bit_err = can_rx_pkg::ERR_FORM;
					else if (crc_value != cur.crc)
						bit_err = can_rx_pkg::ERR_CRC;
				// No receiver acknowledged
				can_rx_pkg::ST_ACK_SLOT:
					if (rx_bit)
						bit_err = can_rx_pkg::ERR_ACK;
				can_rx_pkg::ST_ACK_DELIM,
				can_rx_pkg::ST_EOF,
				can_rx_pkg::ST_INTERMISSION:
					if (!rx_bit)
						bit_err = can_rx_pkg::ERR_FORM;
				default: ;
			endcase
		end
	end

	// ====================
	// Next state
	// ====================

	always_comb
	begin
		state_next = state;
		if (bit_err != can_rx_pkg::ERR_NONE)
			state_next = can_rx_pkg::ST_ERROR_WAIT;
		else
		begin
			case (state)
				// Dominant bit is SOF
				can_rx_pkg::ST_IDLE:
					if (!rx_bit)
						state_next = can_rx_pkg::ST_ID_A;
				can_rx_pkg::ST_ID_A:
					if (field_done)
						state_next = can_rx_pkg::ST_SRR_RTR;
				can_rx_pkg::ST_SRR_RTR:
					state_next = can_rx_pkg::ST_IDE;
				// Standard frames go straight to r0
				can_rx_pkg::ST_IDE:
					state_next = rx_bit ? can_rx_pkg::ST_ID_B : can_rx_pkg::ST_RES0;
				can_rx_pkg::ST_ID_B:
					if (field_done)
						state_next = can_rx_pkg::ST_RTR;
				can_rx_pkg::ST_RTR:
					state_next = can_rx_pkg::ST_RES1;
				can_rx_pkg::ST_RES1:
					state_next = can_rx_pkg::ST_RES0;
				can_rx_pkg::ST_RES0:
					state_next = can_rx_pkg::ST_DLC;
				// Remote frames and DLC 0 carry no data
				can_rx_pkg::ST_DLC:
					if (field_done)
						state_next = (cur.rtr || (dlc_next == '0)) ?
							can_rx_pkg::ST_CRC : can_rx_pkg::ST_DATA;
				can_rx_pkg::ST_DATA:
					if (field_done)
						state_next = can_rx_pkg::ST_CRC;
				can_rx_pkg::ST_CRC:
					if (field_done)
						state_next = can_rx_pkg::ST_CRC_DELIM;
				can_rx_pkg::ST_CRC_DELIM:
					state_next = can_rx_pkg::ST_ACK_SLOT;
				can_rx_pkg::ST_ACK_SLOT:
					state_next = can_rx_pkg::ST_ACK_DELIM;
				can_rx_pkg::ST_ACK_DELIM:
					state_next = can_rx_pkg::ST_EOF;
				can_rx_pkg::ST_EOF:
					if (field_done)
						state_next = can_rx_pkg::ST_INTERMISSION;
				can_rx_pkg::ST_INTERMISSION:
					if (field_done)
						state_next = can_rx_pkg::ST_IDLE;
				// Seven recessive bits in a row end recovery
				can_rx_pkg::ST_ERROR_WAIT:
					if (rx_bit && field_done)
						state_next = can_rx_pkg::ST_IDLE;
				default:
					state_next = can_rx_pkg::ST_IDLE;
			endcase
		end
	end

	// Last EOF bit accepted
	assign frame_done = bit_strobe && (state == can_rx_pkg::ST_EOF) &&
		(state_next == can_rx_pkg::ST_INTERMISSION);

	// ====================
	// Destuffer and CRC control
	// ====================

	// Stuffed region ID_A through CRC, SOF counted by the destuffer in IDLE
	assign stuff_enable = state inside {can_rx_pkg::ST_ID_A, can_rx_pkg::ST_SRR_RTR,
		can_rx_pkg::ST_IDE, can_rx_pkg::ST_ID_B, can_rx_pkg::ST_RTR, can_rx_pkg::ST_RES1,
		can_rx_pkg::ST_RES0, can_rx_pkg::ST_DLC, can_rx_pkg::ST_DATA, can_rx_pkg::ST_CRC};

	// SOF is dominant, so clearing equals shifting it into a zero register
	assign crc_clear = bit_strobe && (state == can_rx_pkg::ST_IDLE) && !rx_bit;
	// CRC covers everything up to the last data bit
	assign crc_shift = bit_strobe && !stuff_error && stuff_enable &&
		(state != can_rx_pkg::ST_CRC);

	// ====================
	// Control registers
	// ====================

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state       <= can_rx_pkg::ST_IDLE;
			bit_cnt     <= '0;
			frame_valid <= 1'b0;
			error_valid <= 1'b0;
			error_kind  <= can_rx_pkg::ERR_NONE;
		end
		else
		begin
			frame_valid <= frame_done;
			error_valid <= bit_strobe && (bit_err != can_rx_pkg::ERR_NONE);
			if (bit_strobe)
			begin
				state <= state_next;
				// New field, or a dominant bit breaking the recovery run
				if ((state_next != state) || ((state == can_rx_pkg::ST_ERROR_WAIT) && !rx_bit))
					bit_cnt <= '0;
				else
					bit_cnt <= bit_cnt + 7'd1;
				if (bit_err != can_rx_pkg::ERR_NONE)
					error_kind <= bit_err;
			end
		end
	end

	// ====================
	// Field capture
	// ====================

	always_ff @(posedge clock)
	begin
		if (bit_strobe)
		begin
			// All fields shift in MSB first
			case (state)
				can_rx_pkg::ST_IDLE:
					if (!rx_bit)
						cur <= '0;
				can_rx_pkg::ST_ID_A:
					cur.id_a <= can_rx_pkg::can_id_a_t'({cur.id_a, rx_bit});
				// RTR for standard frames, SRR for extended ones
				can_rx_pkg::ST_SRR_RTR:
					cur.rtr <= rx_bit;
				can_rx_pkg::ST_IDE:
					cur.ide <= rx_bit;
				can_rx_pkg::ST_ID_B:
					cur.id_b <= can_rx_pkg::can_id_b_t'({cur.id_b, rx_bit});
				can_rx_pkg::ST_RTR:
					cur.rtr <= rx_bit;
				can_rx_pkg::ST_DLC:
					cur.dlc <= dlc_next;
				can_rx_pkg::ST_DATA:
					cur.data <= can_rx_pkg::can_data_t'({cur.data, rx_bit});
				can_rx_pkg::ST_CRC:
					cur.crc <= can_rx_pkg::can_crc_t'({cur.crc, rx_bit});
				default: ;
			endcase
		end
		// Output copy holds until the next good frame
		if (frame_done)
			frame <= cur;
	end

	// One result per frame
	a_one_result: assert property (@(posedge clock) disable iff (reset)
		!(frame_valid && error_valid));

endmodule

/* can_rx.sv */
`timescale 1ns/10ps

module can_rx (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   rx_bit,
	input  logic                   sample_point,
	output can_rx_pkg::can_frame_t frame,
	output logic                   frame_valid,
	output can_rx_pkg::can_error_t error_kind,
	output logic                   error_valid
);

	// Sample point minus removed stuff bits
	logic                 bit_strobe;
	logic                 stuff_error;
	// Stuffed region from the frame FSM
	logic                 stuff_enable;
	logic                 crc_clear;
	logic                 crc_shift;
	can_rx_pkg::can_crc_t crc_value;

	// ====================
	// Bit level
	// ====================

	can_destuffer u_destuffer (
		.clock        (clock),
		.reset        (reset),
		.rx_bit       (rx_bit),
		.sample_point (sample_point),
		.stuff_enable (stuff_enable),
		.bit_strobe   (bit_strobe),
		.stuff_error  (stuff_error)
	);

	// CRC sees the raw bus bit, gated by the FSM shift strobe
	can_crc15 u_crc15 (
		.clock     (clock),
		.reset     (reset),
		.crc_clear (crc_clear),
		.crc_shift (crc_shift),
		.data_bit  (rx_bit),
		.crc_value (crc_value)
	);

	// ====================
	// Frame level
	// ====================

	can_frame_fsm u_frame_fsm (
		.clock        (clock),
		.reset        (reset),
		.rx_bit       (rx_bit),
		.bit_strobe   (bit_strobe),
		.stuff_error  (stuff_error),
		.crc_value    (crc_value),
		.stuff_enable (stuff_enable),
		.crc_clear    (crc_clear),
		.crc_shift    (crc_shift),
		.frame        (frame),
		.frame_valid  (frame_valid),
		.error_kind   (error_kind),
		.error_valid  (error_valid)
	);

endmodule

/* tb_can_rx_clock.sv */
`timescale 1ns/10ps

module tb_can_rx_clock (
	output logic clock,
	output logic reset
);

	// 100 ns period, reset held over the first two rising edges
	initial
	begin
		clock = 1'b0;
		reset = 1'b1;
		repeat (2) @(posedge clock);
		reset <= 1'b0;
	end

	always #50 clock = !clock;

endmodule

/* tb_can_rx.sv */
`timescale 1ns/10ps

module tb_can_rx;

	// Cycle budget for any single wait
	localparam int TIMEOUT_CYCLES = 4000;

	// Which part of a frame gets broken on purpose
	typedef enum logic [2:0] {
		CORRUPT_NONE,
		CORRUPT_STUFF,
		CORRUPT_CRC,
		CORRUPT_DELIM,
		CORRUPT_ACK
	} corrupt_t;

	logic                   clock;
	logic                   reset;
	logic                   rx_bit;
	logic                   sample_point;
	can_rx_pkg::can_frame_t frame;
	logic                   frame_valid;
	can_rx_pkg::can_error_t error_kind;
	logic                   error_valid;
	// FSM state for timeout messages only
	can_rx_pkg::can_state_t fsm_state;

	// Results collected from the valid pulses
	can_rx_pkg::can_frame_t got_frames[$];
	can_rx_pkg::can_error_t got_errors[$];
	// Unstuffed bits SOF through CRC
	logic                   raw_bits[$];
	// Bus bits of one frame with stuffing and tail
	logic                   tx_bits[$];
	logic [31:0]            rng_state;

	tb_can_rx_clock u_clock (
		.clock (clock),
		.reset (reset)
	);

	can_rx u_can_rx (
		.clock        (clock),
		.reset        (reset),
		.rx_bit       (rx_bit),
		.sample_point (sample_point),
		.frame        (frame),
		.frame_valid  (frame_valid),
		.error_kind   (error_kind),
		.error_valid  (error_valid)
	);

	assign fsm_state = u_can_rx.u_frame_fsm.state;

	// Outputs sampled on the edge after each pulse
	always @(posedge clock)
	begin
		if (frame_valid)
			got_frames.push_back(frame);
		if (error_valid)
			got_errors.push_back(error_kind);
	end

	// ====================
	// Failure reporting
	// ====================

	task automatic abort_run();
		$display("tests failed");
		$fatal(1, "stopping at the first failure");
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		abort_run();
	endtask

	task automatic compare_frame(input string name, input can_rx_pkg::can_frame_t expected,
		input can_rx_pkg::can_frame_t actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
			abort_run();
		end
	endtask

	task automatic compare_error(input string name, input can_rx_pkg::can_error_t expected,
		input can_rx_pkg::can_error_t actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %0t %s expected %s actual %s", $time, name, expected.name(),
				actual.name());
			abort_run();
		end
	endtask

	// ====================
	// Stimulus helpers
	// ====================

	// LCG over the full 32-bit state
	function automatic logic [31:0] random_word();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// CAN CRC-15 with generator x^15 + x^14 + x^10 + x^8 + x^7 + x^4 + x^3 + 1
	function automatic can_rx_pkg::can_crc_t crc15_of(input logic bits[$]);
		can_rx_pkg::can_crc_t crc;
		logic                 fb;
		crc = '0;
		foreach (bits[i])
		begin
			fb = bits[i] ^ crc[14];
			crc = {crc[13:0], 1'b0};
			if (fb)
				crc = crc ^ 15'h4599;
		end
		return crc;
	endfunction

	task automatic push_field(input logic [63:0] value, input int width);
		for (int i = width - 1; i >= 0; i--)
			raw_bits.push_back(value[i]);
	endtask

	task automatic random_frame(input int dlc, input logic ide, input logic rtr,
		output can_rx_pkg::can_frame_t f);
		logic [31:0] w;
		w = random_word();
		f = '0;
		f.id_a = w[10:0];
		f.id_b = w[31:14];
		f.ide = ide;
		f.rtr = rtr;
		f.dlc = 4'(dlc);
		f.data = {random_word(), random_word()};
	endtask

	// Fills tx_bits and fixes up f into the frame the DUT should report
	task automatic build_frame(inout can_rx_pkg::can_frame_t f, input corrupt_t corrupt);
		int                   nbits;
		int                   run;
		int                   stuff_at;
		logic                 last;
		can_rx_pkg::can_crc_t crc_tx;
		raw_bits.delete();
		tx_bits.delete();
		// SOF, then the arbitration and control fields
		raw_bits.push_back(1'b0);
		push_field(64'(f.id_a), 11);
		if (f.ide)
		begin
			// SRR and IDE recessive
			raw_bits.push_back(1'b1);
			raw_bits.push_back(1'b1);
			push_field(64'(f.id_b), 18);
			raw_bits.push_back(f.rtr);
			raw_bits.push_back(1'b0);
			raw_bits.push_back(1'b0);
		end
		else
		begin
			f.id_b = '0;
			raw_bits.push_back(f.rtr);
			raw_bits.push_back(1'b0);
			raw_bits.push_back(1'b0);
		end
		push_field(64'(f.dlc), 4);
		nbits = 0;
		if (!f.rtr && (f.dlc != 4'd0))
			nbits = (f.dlc > 4'd8) ? 64 : 8 * int'(f.dlc);
		if (nbits < 64)
			f.data &= (64'd1 << nbits) - 64'd1;
		push_field(f.data, nbits);
		f.crc = crc15_of(raw_bits);
		crc_tx = f.crc;
		if (corrupt == CORRUPT_CRC)
			crc_tx[7] = !crc_tx[7];
		push_field(64'(crc_tx), 15);
		// Complement after five equal bits but none after the last CRC bit
		run = 0;
		last = 1'b1;
		stuff_at = -1;
		foreach (raw_bits[i])
		begin
			if (run == 5)
			begin
				// First recessive stuff bit is the one to break
				if ((stuff_at < 0) && !last)
					stuff_at = tx_bits.size();
				tx_bits.push_back(!last);
				last = !last;
				run = 1;
			end
			if (raw_bits[i] == last)
				run++;
			else
				run = 1;
			last = raw_bits[i];
			tx_bits.push_back(raw_bits[i]);
		end
		if (corrupt == CORRUPT_STUFF)
		begin
			if (stuff_at < 0)
				report_failure("frame has no recessive stuff bit to corrupt");
			else
				tx_bits[stuff_at] = 1'b0;
		end
		// CRC delimiter, ACK slot, then ACK delimiter, EOF and intermission
		tx_bits.push_back(corrupt != CORRUPT_DELIM);
		tx_bits.push_back(corrupt == CORRUPT_ACK);
		repeat (10) tx_bits.push_back(1'b1);
	endtask

	// One bus bit with the sample point in its fourth clock
	task automatic send_bit(input logic b);
		@(posedge clock);
		rx_bit <= b;
		sample_point <= 1'b0;
		@(posedge clock);
		@(posedge clock);
		sample_point <= 1'b1;
		@(posedge clock);
		sample_point <= 1'b0;
	endtask

	task automatic send_frame();
		foreach (tx_bits[i])
			send_bit(tx_bits[i]);
	endtask

	task automatic send_idle(input int count);
		repeat (count) send_bit(1'b1);
	endtask

	// ====================
	// Result checks
	// ====================

	task automatic expect_frame(input can_rx_pkg::can_frame_t expected);
		int n;
		n = 0;
		while (got_frames.size() == 0)
		begin
			if (n == TIMEOUT_CYCLES)
				report_failure($sformatf("timeout waiting for frame_valid, FSM in %s",
					fsm_state.name()));
			else
			begin
				@(posedge clock);
				n++;
			end
		end
		compare_frame("frame", expected, got_frames.pop_front());
		if (got_errors.size() != 0)
			report_failure("error_valid pulsed during a good frame");
	endtask

	task automatic expect_error(input can_rx_pkg::can_error_t expected);
		int n;
		n = 0;
		while (got_errors.size() == 0)
		begin
			if (n == TIMEOUT_CYCLES)
				report_failure($sformatf("timeout waiting for error_valid, FSM in %s",
					fsm_state.name()));
			else
			begin
				@(posedge clock);
				n++;
			end
		end
		compare_error("error_kind", expected, got_errors.pop_front());
		if (got_frames.size() != 0)
			report_failure("frame_valid pulsed for a broken frame");
	endtask

	task automatic send_good_frame(input can_rx_pkg::can_frame_t f);
		build_frame(f, CORRUPT_NONE);
		send_frame();
		expect_frame(f);
		send_idle(3);
	endtask

	task automatic send_bad_frame(input can_rx_pkg::can_frame_t f, input corrupt_t corrupt,
		input can_rx_pkg::can_error_t kind);
		build_frame(f, corrupt);
		send_frame();
		expect_error(kind);
		send_idle(2);
	endtask

	// ====================
	// Directed tests
	// ====================

	task automatic test_standard_frames();
		can_rx_pkg::can_frame_t f;
		for (int dlc = 0; dlc <= 8; dlc++)
		begin
			random_frame(dlc, 1'b0, 1'b0, f);
			send_good_frame(f);
		end
	endtask

	task automatic test_extended_remote();
		can_rx_pkg::can_frame_t f;
		random_frame(4, 1'b1, 1'b1, f);
		send_good_frame(f);
		// DLC above eight still carries eight bytes
		random_frame(12, 1'b0, 1'b0, f);
		send_good_frame(f);
	endtask

	task automatic test_stuffing();
		can_rx_pkg::can_frame_t f;
		random_frame(8, 1'b0, 1'b0, f);
		// Long dominant and recessive runs
		f.id_a = '0;
		f.data = 64'h00ff00ff_0000ffff;
		send_good_frame(f);
		send_bad_frame(f, CORRUPT_STUFF, can_rx_pkg::ERR_STUFF);
		random_frame(5, 1'b0, 1'b0, f);
		send_good_frame(f);
	endtask

	task automatic test_crc_error();
		can_rx_pkg::can_frame_t f;
		random_frame(3, 1'b0, 1'b0, f);
		send_bad_frame(f, CORRUPT_CRC, can_rx_pkg::ERR_CRC);
		random_frame(2, 1'b1, 1'b0, f);
		send_good_frame(f);
	endtask

	task automatic test_form_and_ack();
		can_rx_pkg::can_frame_t f;
		random_frame(6, 1'b0, 1'b0, f);
		send_bad_frame(f, CORRUPT_DELIM, can_rx_pkg::ERR_FORM);
		random_frame(1, 1'b0, 1'b0, f);
		send_good_frame(f);
		random_frame(7, 1'b1, 1'b0, f);
		send_bad_frame(f, CORRUPT_ACK, can_rx_pkg::ERR_ACK);
		random_frame(4, 1'b0, 1'b0, f);
		send_good_frame(f);
	endtask

	// Second SOF right after the two intermission bits
	task automatic test_back_to_back();
		can_rx_pkg::can_frame_t first;
		can_rx_pkg::can_frame_t second;
		random_frame(2, 1'b0, 1'b0, first);
		random_frame(8, 1'b1, 1'b0, second);
		build_frame(first, CORRUPT_NONE);
		send_frame();
		build_frame(second, CORRUPT_NONE);
		send_frame();
		expect_frame(first);
		expect_frame(second);
		send_idle(3);
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		while (reset !== 1'b0)
		begin
			if (n == TIMEOUT_CYCLES)
				report_failure("reset never released");
			else
			begin
				@(posedge clock);
				n++;
			end
		end
	endtask

	initial
	begin
		rx_bit = 1'b1;
		sample_point = 1'b0;
		rng_state = 32'he82d;
		wait_reset_release();
		send_idle(4);
		test_standard_frames();
		test_extended_remote();
		test_stuffing();
		test_crc_error();
		test_form_and_ack();
		test_back_to_back();
		send_idle(4);
		if ((got_frames.size() != 0) || (got_errors.size() != 0))
			report_failure("extra result pulse after the last test");
		else
		begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule

/* can_rx.f */
can_rx_pkg.sv
can_destuffer.sv
can_crc15.sv
can_frame_fsm.sv
can_rx.sv
tb_can_rx_clock.sv
tb_can_rx.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_can_rx
FILELIST  ?= can_rx.f
LOG       ?= sim.log
BUILD_DIR ?= obj_dir

PASS_TEXT := all tests passed
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulation is ignored, the log decides
run: build
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qxF "$(PASS_TEXT)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
